// File: hw/exec_pkg.sv
package exec_pkg;

    localparam int XLEN        = 32;
    localparam int EX_LANES    = 4;
    localparam int ROB_DEPTH   = 8;
    localparam int TAG_W       = 3;
    localparam int IN_CREDITS  = 2;
    localparam int OUT_CREDITS = 2;
    localparam int MUL_STEPS   = 32;

    // Counter and pointer widths derived from the sizes above
    localparam int LANE_W    = $clog2(EX_LANES);
    localparam int ROB_CNT_W = TAG_W + 1;
    localparam int Q_PTR_W   = $clog2(IN_CREDITS);
    localparam int Q_CNT_W   = $clog2(IN_CREDITS + 1);
    localparam int CRED_W    = $clog2(OUT_CREDITS + 1);
    localparam int MUL_CNT_W = $clog2(MUL_STEPS + 1);

    typedef enum logic [5:0] {
        ADD, SUB, AND, OR, XOR, NOR,
        SLL, SRL, SRA, SLT, SLTU,
        ADDI, LUI, PCADD,
        MUL, MULH, MULHU,
        LD_W, LD_H, ST_W, ST_H,
        BEQ, BNE, BLT, BGEU, JIRL
    } op_e;

    typedef struct packed {
        op_e         op;
        logic [4:0]  rd;
        logic [4:0]  rj;
        logic [4:0]  rk;
        logic [10:0] pad;
    } reg_form_t;

    typedef struct packed {
        op_e         op;
        logic [4:0]  rd;
        logic [4:0]  rj;
        logic [15:0] si16;
    } imm_form_t;

    // Same 32-bit word, two decodings
    typedef union packed {
        reg_form_t reg_f;
        imm_form_t imm_f;
    } instr_word_u;

endpackage

// File: hw/iter_mul.sv
module iter_mul (
    input  logic                      clk,
    input  logic                      rst_i,
    input  logic                      start_i,
    input  logic [5:0]                op_i,
    input  logic [exec_pkg::XLEN-1:0] a_i,
    input  logic [exec_pkg::XLEN-1:0] b_i,
    output logic                      done_o,
    output logic [exec_pkg::XLEN-1:0] product_o
);

    logic [2*exec_pkg::XLEN-1:0]    prod, mcand, full;
    logic [exec_pkg::XLEN-1:0]      mplier, mag_a, mag_b;
    logic [exec_pkg::MUL_CNT_W-1:0] cnt;
    logic                           active, neg, high;
    logic                           is_signed, a_neg, b_neg;

    // MULHU is the only unsigned flavour
    assign is_signed = op_i != exec_pkg::MULHU;
    assign a_neg     = is_signed && a_i[exec_pkg::XLEN-1];
    assign b_neg     = is_signed && b_i[exec_pkg::XLEN-1];
    assign mag_a     = a_neg ? -a_i : a_i;
    assign mag_b     = b_neg ? -b_i : b_i;

    assign done_o    = active && (cnt == (exec_pkg::MUL_CNT_W)'(exec_pkg::MUL_STEPS));
    assign full      = neg ? -prod : prod;
    assign product_o = high ? full[2*exec_pkg::XLEN-1:exec_pkg::XLEN]
                            : full[exec_pkg::XLEN-1:0];

    always_ff @(posedge clk) begin
        if (rst_i) begin
            active <= 1'b0;
        end else if (start_i) begin
            active <= 1'b1;
        end else if (done_o) begin
            active <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (start_i) begin
            cnt    <= '0;
            prod   <= '0;
            mcand  <= {{exec_pkg::XLEN{1'b0}}, mag_a};
            mplier <= mag_b;
            neg    <= a_neg ^ b_neg;
            high   <= op_i != exec_pkg::MUL;
        end else if (active && !done_o) begin
            if (mplier[0]) begin
                prod <= prod + mcand;
            end
            mcand  <= mcand << 1;
            mplier <= mplier >> 1;
            cnt    <= cnt + (exec_pkg::MUL_CNT_W)'(1);
        end
    end

endmodule

// File: hw/exec_lane.sv
module exec_lane (
    input  logic                       clk,
    input  logic                       rst_i,
    input  logic                       issue_valid_i,
    input  logic [exec_pkg::TAG_W-1:0] issue_tag_i,
    input  logic [exec_pkg::XLEN-1:0]  issue_instr_i,
    input  logic [exec_pkg::XLEN-1:0]  issue_pc_i,
    input  logic [exec_pkg::XLEN-1:0]  issue_src1_i,
    input  logic [exec_pkg::XLEN-1:0]  issue_src2_i,
    input  logic                       res_taken_i,
    output logic                       res_valid_o,
    output logic [exec_pkg::TAG_W-1:0] res_tag_o,
    output logic [exec_pkg::XLEN-1:0]  res_wdata_o,
    output logic [4:0]                 res_rd_o,
    output logic                       res_br_taken_o,
    output logic [exec_pkg::XLEN-1:0]  res_br_target_o,
    output logic                       res_excp_ale_o
);

    exec_pkg::instr_word_u     word;
    exec_pkg::op_e             op;
    logic [15:0]               si16;
    logic [exec_pkg::XLEN-1:0] a, b, imm, addr;
    logic [exec_pkg::XLEN-1:0] wdata, target, product;
    logic                      is_reg, is_mul, taken, ale, mul_done;

    assign word = issue_instr_i;
    assign op   = word.reg_f.op;
    assign si16 = word.imm_f.si16;
    assign a    = issue_src1_i;

    always_comb begin
        is_reg = 1'b0;
        is_mul = 1'b0;
        imm    = {{16{si16[15]}}, si16};
        case (op)
            exec_pkg::ADD, exec_pkg::SUB, exec_pkg::AND, exec_pkg::OR,
            exec_pkg::XOR, exec_pkg::NOR, exec_pkg::SLL, exec_pkg::SRL,
            exec_pkg::SRA, exec_pkg::SLT, exec_pkg::SLTU: is_reg = 1'b1;
            exec_pkg::MUL, exec_pkg::MULH, exec_pkg::MULHU: begin
                is_reg = 1'b1;
                is_mul = 1'b1;
            end
            exec_pkg::LUI: imm = {si16, 16'b0};
            exec_pkg::BEQ, exec_pkg::BNE, exec_pkg::BLT, exec_pkg::BGEU,
            exec_pkg::JIRL: imm = {{14{si16[15]}}, si16, 2'b00};
            default: ;
        endcase
    end

    assign b    = is_reg ? issue_src2_i : imm;
    assign addr = a + b;

    always_comb begin
        wdata  = '0;
        taken  = 1'b0;
        target = issue_pc_i + imm;
        ale    = 1'b0;
        case (op)
            exec_pkg::ADD, exec_pkg::ADDI: wdata = addr;
            exec_pkg::SUB:   wdata = a - b;
            exec_pkg::AND:   wdata = a & b;
            exec_pkg::OR:    wdata = a | b;
            exec_pkg::XOR:   wdata = a ^ b;
            exec_pkg::NOR:   wdata = ~(a | b);
            exec_pkg::SLL:   wdata = a << b[4:0];
            exec_pkg::SRL:   wdata = a >> b[4:0];
            exec_pkg::SRA:   wdata = $signed(a) >>> b[4:0];
            exec_pkg::SLT:   wdata = {31'b0, $signed(a) < $signed(b)};
            exec_pkg::SLTU:  wdata = {31'b0, a < b};
            exec_pkg::LUI:   wdata = b;
            exec_pkg::PCADD: wdata = issue_pc_i + b;
            exec_pkg::LD_W, exec_pkg::ST_W: begin
                wdata = addr;
                ale   = addr[1:0] != 2'b00;
            end
            exec_pkg::LD_H, exec_pkg::ST_H: begin
                wdata = addr;
                ale   = addr[0];
            end
            // Branch compares use the register values, not the offset
            exec_pkg::BEQ:  taken = a == issue_src2_i;
            exec_pkg::BNE:  taken = a != issue_src2_i;
            exec_pkg::BLT:  taken = $signed(a) < $signed(issue_src2_i);
            exec_pkg::BGEU: taken = a >= issue_src2_i;
            exec_pkg::JIRL: begin
                taken  = 1'b1;
                target = addr;
            end
            default: ;
        endcase
        if (op inside {exec_pkg::BEQ, exec_pkg::BNE, exec_pkg::BLT,
                       exec_pkg::BGEU, exec_pkg::JIRL}) begin
            wdata = issue_pc_i + 32'd4;
        end
    end

    iter_mul u_iter_mul (
        .clk       (clk),
        .rst_i     (rst_i),
        .start_i   (issue_valid_i && is_mul),
        .op_i      (op),
        .a_i       (a),
        .b_i       (issue_src2_i),
        .done_o    (mul_done),
        .product_o (product)
    );

    always_ff @(posedge clk) begin
        if (rst_i) begin
            res_valid_o <= 1'b0;
        end else if (mul_done || (issue_valid_i && !is_mul)) begin
            res_valid_o <= 1'b1;
        end else if (res_taken_i) begin
            res_valid_o <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (issue_valid_i) begin
            res_tag_o       <= issue_tag_i;
            res_rd_o        <= word.reg_f.rd;
            res_wdata_o     <= wdata;
            res_br_taken_o  <= taken;
            res_br_target_o <= target;
            res_excp_ale_o  <= ale;
        end else if (mul_done) begin
            res_wdata_o <= product;
        end
    end

endmodule

// File: hw/exec_dispatch.sv
module exec_dispatch (
    input  logic                         clk,
    input  logic                         rst_i,
    input  logic                         in_valid_i,
    input  logic [exec_pkg::XLEN-1:0]    in_instr_i,
    input  logic [exec_pkg::XLEN-1:0]    in_pc_i,
    input  logic [exec_pkg::XLEN-1:0]    in_src1_i,
    input  logic [exec_pkg::XLEN-1:0]    in_src2_i,
    input  logic [exec_pkg::EX_LANES-1:0] lane_credit_i,
    input  logic                         rob_credit_i,
    output logic                         in_credit_o,
    output logic [exec_pkg::EX_LANES-1:0] issue_valid_o,
    output logic [exec_pkg::TAG_W-1:0]   issue_tag_o,
    output logic [exec_pkg::XLEN-1:0]    issue_instr_o,
    output logic [exec_pkg::XLEN-1:0]    issue_pc_o,
    output logic [exec_pkg::XLEN-1:0]    issue_src1_o,
    output logic [exec_pkg::XLEN-1:0]    issue_src2_o
);

    logic [exec_pkg::XLEN-1:0]      q_instr [exec_pkg::IN_CREDITS];
    logic [exec_pkg::XLEN-1:0]      q_pc    [exec_pkg::IN_CREDITS];
    logic [exec_pkg::XLEN-1:0]      q_src1  [exec_pkg::IN_CREDITS];
    logic [exec_pkg::XLEN-1:0]      q_src2  [exec_pkg::IN_CREDITS];
    logic [exec_pkg::Q_PTR_W-1:0]   wr_ptr, rd_ptr;
    logic [exec_pkg::Q_CNT_W-1:0]   q_cnt;
    logic [exec_pkg::ROB_CNT_W-1:0] rob_cnt;
    logic [exec_pkg::TAG_W-1:0]     tag_cnt;
    logic [exec_pkg::EX_LANES-1:0]  lane_busy;
    logic [exec_pkg::LANE_W-1:0]    rr_ptr, sel;
    logic                           found, fire;

    // Search starts one past the last lane used
    always_comb begin
        logic [exec_pkg::LANE_W-1:0] idx;
        found = 1'b0;
        sel   = rr_ptr;
        for (int i = 1; i <= exec_pkg::EX_LANES; i++) begin
            idx = rr_ptr + (exec_pkg::LANE_W)'(i);
            if (!found && !lane_busy[idx]) begin
                found = 1'b1;
                sel   = idx;
            end
        end
    end

    assign fire = (q_cnt != '0) && found && (rob_cnt != '0);

    always_comb begin
        issue_valid_o = '0;
        if (fire) begin
            issue_valid_o[sel] = 1'b1;
        end
    end

    assign in_credit_o   = fire;
    assign issue_tag_o   = tag_cnt;
    assign issue_instr_o = q_instr[rd_ptr];
    assign issue_pc_o    = q_pc[rd_ptr];
    assign issue_src1_o  = q_src1[rd_ptr];
    assign issue_src2_o  = q_src2[rd_ptr];

    always_ff @(posedge clk) begin
        if (rst_i) begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            q_cnt     <= '0;
            rob_cnt   <= (exec_pkg::ROB_CNT_W)'(exec_pkg::ROB_DEPTH);
            tag_cnt   <= '0;
            lane_busy <= '0;
            rr_ptr    <= (exec_pkg::LANE_W)'(exec_pkg::EX_LANES - 1);
        end else begin
            q_cnt     <= q_cnt + (exec_pkg::Q_CNT_W)'(in_valid_i) - (exec_pkg::Q_CNT_W)'(fire);
            rob_cnt   <= rob_cnt + (exec_pkg::ROB_CNT_W)'(rob_credit_i)
                         - (exec_pkg::ROB_CNT_W)'(fire);
            lane_busy <= (lane_busy | issue_valid_o) & ~lane_credit_i;
            if (in_valid_i) begin
                wr_ptr <= wr_ptr + (exec_pkg::Q_PTR_W)'(1);
            end
            if (fire) begin
                rd_ptr  <= rd_ptr + (exec_pkg::Q_PTR_W)'(1);
                tag_cnt <= tag_cnt + (exec_pkg::TAG_W)'(1);
                rr_ptr  <= sel;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid_i) begin
            q_instr[wr_ptr] <= in_instr_i;
            q_pc[wr_ptr]    <= in_pc_i;
            q_src1[wr_ptr]  <= in_src1_i;
            q_src2[wr_ptr]  <= in_src2_i;
        end
    end

endmodule

// File: hw/exec_retire.sv
module exec_retire (
    input  logic                          clk,
    input  logic                          rst_i,
    input  logic [exec_pkg::EX_LANES-1:0] res_valid_i,
    input  logic [exec_pkg::TAG_W-1:0]    res_tag_i       [exec_pkg::EX_LANES],
    input  logic [exec_pkg::XLEN-1:0]     res_wdata_i     [exec_pkg::EX_LANES],
    input  logic [4:0]                    res_rd_i        [exec_pkg::EX_LANES],
    input  logic [exec_pkg::EX_LANES-1:0] res_br_taken_i,
    input  logic [exec_pkg::XLEN-1:0]     res_br_target_i [exec_pkg::EX_LANES],
    input  logic [exec_pkg::EX_LANES-1:0] res_excp_ale_i,
    input  logic                          out_credit_i,
    output logic [exec_pkg::EX_LANES-1:0] lane_credit_o,
    output logic                          rob_credit_o,
    output logic                          out_valid_o,
    output logic [exec_pkg::XLEN-1:0]     out_wdata_o,
    output logic [4:0]                    out_rd_o,
    output logic                          out_br_taken_o,
    output logic [exec_pkg::XLEN-1:0]     out_br_target_o,
    output logic                          out_excp_ale_o
);

    logic [exec_pkg::XLEN-1:0]      slot_wdata  [exec_pkg::ROB_DEPTH];
    logic [4:0]                     slot_rd     [exec_pkg::ROB_DEPTH];
    logic [exec_pkg::XLEN-1:0]      slot_target [exec_pkg::ROB_DEPTH];
    logic [exec_pkg::ROB_DEPTH-1:0] slot_taken, slot_ale, filled;
    logic [exec_pkg::TAG_W-1:0]     head;
    logic [exec_pkg::CRED_W-1:0]    out_cnt;
    logic                           fire;

    // Every valid result is written this cycle, so the lane is free at once
    assign lane_credit_o = res_valid_i;
    assign fire          = filled[head] && (out_cnt != '0);

    always_ff @(posedge clk) begin
        if (rst_i) begin
            filled       <= '0;
            head         <= '0;
            out_cnt      <= (exec_pkg::CRED_W)'(exec_pkg::OUT_CREDITS);
            out_valid_o  <= 1'b0;
            rob_credit_o <= 1'b0;
        end else begin
            out_valid_o  <= fire;
            rob_credit_o <= fire;
            out_cnt      <= out_cnt + (exec_pkg::CRED_W)'(out_credit_i)
                            - (exec_pkg::CRED_W)'(fire);
            if (fire) begin
                filled[head] <= 1'b0;
                head         <= head + (exec_pkg::TAG_W)'(1);
            end
            for (int k = 0; k < exec_pkg::EX_LANES; k++) begin
                if (res_valid_i[k]) begin
                    filled[res_tag_i[k]] <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int k = 0; k < exec_pkg::EX_LANES; k++) begin
            if (res_valid_i[k]) begin
                slot_wdata[res_tag_i[k]]  <= res_wdata_i[k];
                slot_rd[res_tag_i[k]]     <= res_rd_i[k];
                slot_taken[res_tag_i[k]]  <= res_br_taken_i[k];
                slot_target[res_tag_i[k]] <= res_br_target_i[k];
                slot_ale[res_tag_i[k]]    <= res_excp_ale_i[k];
            end
        end
        if (fire) begin
            out_wdata_o     <= slot_wdata[head];
            out_rd_o        <= slot_rd[head];
            out_br_taken_o  <= slot_taken[head];
            out_br_target_o <= slot_target[head];
            out_excp_ale_o  <= slot_ale[head];
        end
    end

endmodule

// File: hw/exec_cluster.sv
module exec_cluster (
    input  logic                      clk,
    input  logic                      rst_i,
    input  logic                      in_valid_i,
    input  logic [exec_pkg::XLEN-1:0] in_instr_i,
    input  logic [exec_pkg::XLEN-1:0] in_pc_i,
    input  logic [exec_pkg::XLEN-1:0] in_src1_i,
    input  logic [exec_pkg::XLEN-1:0] in_src2_i,
    input  logic                      out_credit_i,
    output logic                      in_credit_o,
    output logic                      out_valid_o,
    output logic [exec_pkg::XLEN-1:0] out_wdata_o,
    output logic [4:0]                out_rd_o,
    output logic                      out_br_taken_o,
    output logic [exec_pkg::XLEN-1:0] out_br_target_o,
    output logic                      out_excp_ale_o
);

    logic [exec_pkg::EX_LANES-1:0] issue_valid, lane_credit;
    logic [exec_pkg::EX_LANES-1:0] res_valid, res_br_taken, res_excp_ale;
    logic [exec_pkg::TAG_W-1:0]    issue_tag;
    logic [exec_pkg::XLEN-1:0]     issue_instr, issue_pc, issue_src1, issue_src2;
    logic [exec_pkg::TAG_W-1:0]    res_tag       [exec_pkg::EX_LANES];
    logic [exec_pkg::XLEN-1:0]     res_wdata     [exec_pkg::EX_LANES];
    logic [4:0]                    res_rd        [exec_pkg::EX_LANES];
    logic [exec_pkg::XLEN-1:0]     res_br_target [exec_pkg::EX_LANES];
    logic                          rob_credit;

    exec_dispatch u_exec_dispatch (
        .clk           (clk),
        .rst_i         (rst_i),
        .in_valid_i    (in_valid_i),
        .in_instr_i    (in_instr_i),
        .in_pc_i       (in_pc_i),
        .in_src1_i     (in_src1_i),
        .in_src2_i     (in_src2_i),
        .lane_credit_i (lane_credit),
        .rob_credit_i  (rob_credit),
        .in_credit_o   (in_credit_o),
        .issue_valid_o (issue_valid),
        .issue_tag_o   (issue_tag),
        .issue_instr_o (issue_instr),
        .issue_pc_o    (issue_pc),
        .issue_src1_o  (issue_src1),
        .issue_src2_o  (issue_src2)
    );

    for (genvar k = 0; k < exec_pkg::EX_LANES; k++) begin : g_lane
        exec_lane u_exec_lane (
            .clk             (clk),
            .rst_i           (rst_i),
            .issue_valid_i   (issue_valid[k]),
            .issue_tag_i     (issue_tag),
            .issue_instr_i   (issue_instr),
            .issue_pc_i      (issue_pc),
            .issue_src1_i    (issue_src1),
            .issue_src2_i    (issue_src2),
            .res_taken_i     (lane_credit[k]),
            .res_valid_o     (res_valid[k]),
            .res_tag_o       (res_tag[k]),
            .res_wdata_o     (res_wdata[k]),
            .res_rd_o        (res_rd[k]),
            .res_br_taken_o  (res_br_taken[k]),
            .res_br_target_o (res_br_target[k]),
            .res_excp_ale_o  (res_excp_ale[k])
        );
    end

    exec_retire u_exec_retire (
        .clk             (clk),
        .rst_i           (rst_i),
        .res_valid_i     (res_valid),
        .res_tag_i       (res_tag),
        .res_wdata_i     (res_wdata),
        .res_rd_i        (res_rd),
        .res_br_taken_i  (res_br_taken),
        .res_br_target_i (res_br_target),
        .res_excp_ale_i  (res_excp_ale),
        .out_credit_i    (out_credit_i),
        .lane_credit_o   (lane_credit),
        .rob_credit_o    (rob_credit),
        .out_valid_o     (out_valid_o),
        .out_wdata_o     (out_wdata_o),
        .out_rd_o        (out_rd_o),
        .out_br_taken_o  (out_br_taken_o),
        .out_br_target_o (out_br_target_o),
        .out_excp_ale_o  (out_excp_ale_o)
    );

endmodule

// File: testbench/tb_clock.sv
module tb_clock (
    output logic clk_o
);

    localparam int HALF_PERIOD = 20;

    initial begin
        clk_o = 1'b0;
        forever begin
            #HALF_PERIOD clk_o = ~clk_o;
        end
    end

endmodule

// File: include/exec_ref.svh
`ifndef EXEC_REF_SVH
`define EXEC_REF_SVH

// Expected lane result for one operation
function automatic void exec_ref(input logic [31:0] instr, input logic [31:0] pc,
                                 input logic [31:0] a, input logic [31:0] b,
                                 output logic [31:0] wdata, output logic taken,
                                 output logic [31:0] target, output logic ale);
    exec_pkg::instr_word_u w;
    logic signed [63:0]    sp;
    logic [63:0]           up;
    logic [31:0]           si, off;
    w      = instr;
    si     = {{16{w.imm_f.si16[15]}}, w.imm_f.si16};
    off    = si << 2;
    sp     = $signed({{32{a[31]}}, a}) * $signed({{32{b[31]}}, b});
    up     = {32'b0, a} * {32'b0, b};
    wdata  = '0;
    taken  = 1'b0;
    target = pc + off;
    ale    = 1'b0;
    case (w.reg_f.op)
        exec_pkg::ADD:   wdata = a + b;
        exec_pkg::SUB:   wdata = a - b;
        exec_pkg::AND:   wdata = a & b;
        exec_pkg::OR:    wdata = a | b;
        exec_pkg::XOR:   wdata = a ^ b;
        exec_pkg::NOR:   wdata = ~(a | b);
        exec_pkg::SLL:   wdata = a << b[4:0];
        exec_pkg::SRL:   wdata = a >> b[4:0];
        exec_pkg::SRA:   wdata = $signed(a) >>> b[4:0];
        exec_pkg::SLT:   wdata = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
        exec_pkg::SLTU:  wdata = (a < b) ? 32'd1 : 32'd0;
        exec_pkg::ADDI:  wdata = a + si;
        exec_pkg::LUI:   wdata = {w.imm_f.si16, 16'b0};
        exec_pkg::PCADD: wdata = pc + si;
        exec_pkg::MUL:   wdata = sp[31:0];
        exec_pkg::MULH:  wdata = sp[63:32];
        exec_pkg::MULHU: wdata = up[63:32];
        exec_pkg::LD_W, exec_pkg::ST_W, exec_pkg::LD_H, exec_pkg::ST_H: begin
            wdata = a + si;
            ale   = (w.reg_f.op inside {exec_pkg::LD_W, exec_pkg::ST_W}) ?
                    (wdata[1:0] != 2'b00) : wdata[0];
        end
        default: begin
            wdata  = pc + 32'd4;
            taken  = (w.reg_f.op == exec_pkg::BEQ  && a == b) ||
                     (w.reg_f.op == exec_pkg::BNE  && a != b) ||
                     (w.reg_f.op == exec_pkg::BLT  && $signed(a) < $signed(b)) ||
                     (w.reg_f.op == exec_pkg::BGEU && a >= b) ||
                     (w.reg_f.op == exec_pkg::JIRL);
            target = (w.reg_f.op == exec_pkg::JIRL) ? a + off : pc + off;
        end
    endcase
endfunction

`endif

// File: testbench/tb_exec_cluster.sv
module tb_exec_cluster;

    localparam int CLK_PERIOD     = 40;
    localparam int ALU_KINDS      = 14;
    localparam int ALU_ROUNDS     = 2;
    localparam int BR_OPS         = 10;
    localparam int MEM_OPS        = 16;
    localparam int MUL_PAIRS      = 6;
    localparam int MUL_OPS        = MUL_PAIRS * 3 * 2;
    localparam int BP_OPS         = 20;
    localparam int BP_HOLD_CYCLES = 40;
    localparam int TOTAL_OPS      = ALU_KINDS * ALU_ROUNDS + BR_OPS + MEM_OPS + MUL_OPS + BP_OPS;

    logic        clk;
    logic        rst_i        = 1'b1;
    logic        in_valid_i   = 1'b0;
    logic [31:0] in_instr_i   = '0;
    logic [31:0] in_pc_i      = '0;
    logic [31:0] in_src1_i    = '0;
    logic [31:0] in_src2_i    = '0;
    logic        out_credit_i = 1'b0;
    logic        in_credit_o;
    logic        out_valid_o;
    logic [31:0] out_wdata_o;
    logic [4:0]  out_rd_o;
    logic        out_br_taken_o;
    logic [31:0] out_br_target_o;
    logic        out_excp_ale_o;

    // Pending sends and expected results in program order
    logic [31:0] snd_instr [$];
    logic [31:0] snd_pc    [$];
    logic [31:0] snd_a     [$];
    logic [31:0] snd_b     [$];
    logic [31:0] exp_wdata  [$];
    logic [31:0] exp_target [$];
    logic [4:0]  exp_rd     [$];
    // Branch, misaligned, taken
    logic [2:0]  exp_flags  [$];

    int   src_credits   = exec_pkg::IN_CREDITS;
    int   credit_pulses = 0;
    int   sent          = 0;
    int   received      = 0;
    int   owed          = 0;
    int   gap_cnt       = 0;
    int   credit_gap    = 0;
    logic hold_credits  = 1'b0;
    int   check_errors  = 0;
    int   flow_errors   = 0;

    exec_pkg::op_e alu_ops [ALU_KINDS] = '{
        exec_pkg::ADD, exec_pkg::SUB, exec_pkg::AND, exec_pkg::OR, exec_pkg::XOR,
        exec_pkg::NOR, exec_pkg::SLL, exec_pkg::SRL, exec_pkg::SRA, exec_pkg::SLT,
        exec_pkg::SLTU, exec_pkg::ADDI, exec_pkg::LUI, exec_pkg::PCADD
    };

    `include "exec_ref.svh"

    tb_clock u_tb_clock (
        .clk_o (clk)
    );

    exec_cluster u_exec_cluster (
        .clk             (clk),
        .rst_i           (rst_i),
        .in_valid_i      (in_valid_i),
        .in_instr_i      (in_instr_i),
        .in_pc_i         (in_pc_i),
        .in_src1_i       (in_src1_i),
        .in_src2_i       (in_src2_i),
        .out_credit_i    (out_credit_i),
        .in_credit_o     (in_credit_o),
        .out_valid_o     (out_valid_o),
        .out_wdata_o     (out_wdata_o),
        .out_rd_o        (out_rd_o),
        .out_br_taken_o  (out_br_taken_o),
        .out_br_target_o (out_br_target_o),
        .out_excp_ale_o  (out_excp_ale_o)
    );

    function automatic logic [31:0] rand_pc();
        return $urandom & 32'hffff_fffc;
    endfunction

    task automatic compare_field(input string name, input logic [31:0] got,
                                 input logic [31:0] want);
        assert (got === want) else begin
            check_errors++;
            $display("Mismatch at %0t: %s got %h, expected %h", $time, name, got, want);
        end
    endtask

    task automatic check_output();
        logic [2:0]  flags;
        logic [31:0] want_target;
        assert (exp_wdata.size() != 0) else begin
            check_errors++;
            $display("Result at %0t arrived with no operation outstanding", $time);
        end
        if (exp_wdata.size() != 0) begin
            flags       = exp_flags.pop_front();
            want_target = exp_target.pop_front();
            compare_field("wdata", out_wdata_o, exp_wdata.pop_front());
            compare_field("rd", 32'(out_rd_o), 32'(exp_rd.pop_front()));
            compare_field("taken", 32'(out_br_taken_o), 32'(flags[0]));
            compare_field("ale", 32'(out_excp_ale_o), 32'(flags[1]));
            if (flags[2]) begin
                compare_field("target", out_br_target_o, want_target);
            end
        end
    endtask

    // Source and consumer side on the falling edge
    always @(negedge clk) begin
        in_valid_i   = 1'b0;
        out_credit_i = 1'b0;
        if (in_credit_o) begin
            src_credits++;
            credit_pulses++;
        end
        assert (credit_pulses <= sent) else begin
            check_errors++;
            $display("Input credit at %0t returned for an operation never sent", $time);
        end
        if (out_valid_o) begin
            owed++;
            received++;
            check_output();
        end
        if (snd_instr.size() != 0 && src_credits != 0) begin
            in_valid_i = 1'b1;
            in_instr_i = snd_instr.pop_front();
            in_pc_i    = snd_pc.pop_front();
            in_src1_i  = snd_a.pop_front();
            in_src2_i  = snd_b.pop_front();
            src_credits--;
            sent++;
        end
        if (!hold_credits && owed != 0 && gap_cnt >= credit_gap) begin
            out_credit_i = 1'b1;
            owed--;
            gap_cnt = 0;
        end else begin
            gap_cnt++;
        end
    end

    task automatic send_op(input exec_pkg::op_e op, input logic [31:0] pc,
                           input logic [31:0] a, input logic [31:0] b, input logic [15:0] si);
        exec_pkg::instr_word_u w;
        logic [31:0]           wdata;
        logic [31:0]           target;
        logic                  taken;
        logic                  ale;
        if (op inside {exec_pkg::ADD, exec_pkg::SUB, exec_pkg::AND, exec_pkg::OR,
                       exec_pkg::XOR, exec_pkg::NOR, exec_pkg::SLL, exec_pkg::SRL,
                       exec_pkg::SRA, exec_pkg::SLT, exec_pkg::SLTU, exec_pkg::MUL,
                       exec_pkg::MULH, exec_pkg::MULHU}) begin
            w.reg_f.op  = op;
            w.reg_f.rd  = 5'($urandom);
            w.reg_f.rj  = 5'($urandom);
            w.reg_f.rk  = 5'($urandom);
            w.reg_f.pad = 11'($urandom);
        end else begin
            w.imm_f.op   = op;
            w.imm_f.rd   = 5'($urandom);
            w.imm_f.rj   = 5'($urandom);
            w.imm_f.si16 = si;
        end
        exec_ref(w, pc, a, b, wdata, taken, target, ale);
        snd_instr.push_back(w);
        snd_pc.push_back(pc);
        snd_a.push_back(a);
        snd_b.push_back(b);
        exp_wdata.push_back(wdata);
        exp_target.push_back(target);
        exp_rd.push_back(w.reg_f.rd);
        exp_flags.push_back({op inside {exec_pkg::BEQ, exec_pkg::BNE, exec_pkg::BLT,
                                        exec_pkg::BGEU, exec_pkg::JIRL}, ale, taken});
    endtask

    task automatic wait_drain();
        while (snd_instr.size() != 0 || exp_wdata.size() != 0) begin
            @(posedge clk);
        end
    endtask

    task automatic test_alu();
        for (int r = 0; r < ALU_ROUNDS; r++) begin
            foreach (alu_ops[i]) begin
                send_op(alu_ops[i], rand_pc(), $urandom, $urandom, 16'($urandom));
            end
        end
        wait_drain();
    endtask

    task automatic test_branches();
        logic [31:0] x;
        x = $urandom;
        send_op(exec_pkg::BEQ, rand_pc(), x, x, 16'($urandom));
        send_op(exec_pkg::BEQ, rand_pc(), x, x + 32'd1, 16'($urandom));
        send_op(exec_pkg::BNE, rand_pc(), x, x + 32'd1, 16'($urandom));
        send_op(exec_pkg::BNE, rand_pc(), x, x, 16'($urandom));
        // Signed and unsigned orderings disagree on these pairs
        send_op(exec_pkg::BLT, rand_pc(), 32'hffff_fffb, 32'd3, 16'($urandom));
        send_op(exec_pkg::BLT, rand_pc(), 32'd3, 32'hffff_fffb, 16'($urandom));
        send_op(exec_pkg::BGEU, rand_pc(), 32'hffff_fff0, 32'd1, 16'($urandom));
        send_op(exec_pkg::BGEU, rand_pc(), 32'd1, 32'hffff_fff0, 16'($urandom));
        send_op(exec_pkg::JIRL, rand_pc(), x, 32'd0, 16'($urandom));
        send_op(exec_pkg::JIRL, rand_pc(), ~x, 32'd0, 16'($urandom));
        wait_drain();
    endtask

    task automatic test_mem();
        exec_pkg::op_e mem_ops [4];
        logic [31:0]   base;
        mem_ops = '{exec_pkg::LD_W, exec_pkg::LD_H, exec_pkg::ST_W, exec_pkg::ST_H};
        foreach (mem_ops[i]) begin
            // Low offset bits set the address alignment
            for (int off = 0; off < 4; off++) begin
                base = $urandom & 32'hffff_fffc;
                send_op(mem_ops[i], rand_pc(), base, $urandom, {14'($urandom), 2'(off)});
            end
        end
        wait_drain();
    endtask

    task automatic test_mul_order();
        exec_pkg::op_e mul_ops [3];
        logic [31:0]   ma [MUL_PAIRS];
        logic [31:0]   mb [MUL_PAIRS];
        mul_ops = '{exec_pkg::MUL, exec_pkg::MULH, exec_pkg::MULHU};
        ma = '{32'h0, 32'hffff_fff9, 32'h8000_0000, 32'hffff_ffff, 32'h7fff_ffff, 32'h0};
        mb = '{32'h0, 32'h0000_0003, 32'h8000_0000, 32'hffff_ffff, 32'h8000_0000, 32'h0};
        ma[0] = $urandom;
        mb[0] = $urandom;
        mb[5] = $urandom;
        for (int p = 0; p < MUL_PAIRS; p++) begin
            foreach (mul_ops[m]) begin
                // Fast op right behind the slow one
                send_op(mul_ops[m], rand_pc(), ma[p], mb[p], 16'h0);
                send_op(exec_pkg::ADD, rand_pc(), $urandom, $urandom, 16'h0);
            end
        end
        wait_drain();
    endtask

    task automatic test_backpressure();
        int rx_start;
        rx_start     = received;
        hold_credits = 1'b1;
        for (int i = 0; i < BP_OPS; i++) begin
            send_op(alu_ops[$urandom_range(0, ALU_KINDS - 1)], rand_pc(), $urandom,
                    $urandom, 16'($urandom));
        end
        repeat (BP_HOLD_CYCLES) @(posedge clk);
        assert (received - rx_start <= exec_pkg::OUT_CREDITS) else begin
            flow_errors++;
            $display("Results were released beyond the consumer credits granted");
        end
        assert (snd_instr.size() != 0) else begin
            flow_errors++;
            $display("Source never stalled while consumer credits were held back");
        end
        // Slow release
        credit_gap   = 4;
        hold_credits = 1'b0;
        wait_drain();
        credit_gap = 0;
    endtask

    initial begin
        void'($urandom(32'hfdbc3874));
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst_i = 1'b0;
        @(posedge clk);
        test_alu();
        test_branches();
        test_mem();
        test_mul_order();
        test_backpressure();
        // Idle time to expose any duplicate result
        repeat (10) @(posedge clk);
        assert (received == sent) else begin
            flow_errors++;
            $display("Received %0d results for %0d operations sent", received, sent);
        end
        assert (credit_pulses == sent) else begin
            flow_errors++;
            $display("Got %0d input credits for %0d operations sent", credit_pulses, sent);
        end
        $display("Errors: %0d output checks, %0d flow checks", check_errors, flow_errors);
        if (check_errors == 0 && flow_errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

    initial begin
        #((TOTAL_OPS * (exec_pkg::MUL_STEPS + 10) + BP_HOLD_CYCLES) * CLK_PERIOD);
        $display("Timeout: results still outstanding after %0d operations' time", TOTAL_OPS);
        $display("Errors: %0d output checks, %0d flow checks", check_errors, flow_errors);
        $display("sim failed");
        $finish;
    end

endmodule

// File: vlog.f
+incdir+include
hw/exec_pkg.sv
hw/iter_mul.sv
hw/exec_lane.sv
hw/exec_dispatch.sv
hw/exec_retire.sv
hw/exec_cluster.sv
testbench/tb_clock.sv
testbench/tb_exec_cluster.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the execute cluster testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --assert -f vlog.f --top-module tb_exec_cluster \
    --Mdir obj_dir -o tb_exec_cluster
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

out=$(./obj_dir/tb_exec_cluster)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$out" | grep -qx "sim passed"; then
    exit 0
fi
exit 1
